/* hdl/exu_pkg.sv */
package exu_pkg;

  localparam int xlen = 32; // datapath is rv32 only

  // encodings follow instruction bits 6:2
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_e;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_e;

  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  localparam logic [xlen-1:0] cause_ecall = 11; // ecall from m-mode

  // one decoded instruction as handed over by decode
  typedef struct packed {
    logic [xlen-1:0] pc;
    opcode_e         opcode;
    logic [2:0]      funct;
    logic [4:0]      rd;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] imm;       // low 12 bits double as csr address
    logic [xlen-1:0] csr;       // csr read value
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [2:0]      alu_funct;
    logic            alu_funcs; // sub / sra select
  } exu_instr_t;

  typedef struct packed {
    logic            wen;
    logic [11:0]     waddr;
    logic [xlen-1:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic [2:0]      func;  // funct3 width/sign code
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata; // unused for reads
  } mem_req_t;

  typedef struct packed {
    logic    gpr_wen;
    logic    is_load;
    logic    is_store;
    logic    pc_ovrd;  // base from src1 or csr instead of pc
    logic    csr_jump; // ecall / mret
    csr_wr_t csr_wr1;
    csr_wr_t csr_wr2;
  } sys_ctl_t;

endpackage

/* hdl/exu_alu.sv */
`timescale 1ns/10ps

module exu_alu (
  input  logic [exu_pkg::xlen-1:0] alu_a,
  input  logic [exu_pkg::xlen-1:0] alu_b,
  input  logic [2:0]               funct,
  input  logic                     funcs,
  output logic [exu_pkg::xlen-1:0] val
);

  logic [exu_pkg::xlen-1:0] add_res;
  logic [exu_pkg::xlen-1:0] sub_res;
  logic [exu_pkg::xlen-1:0] sra_res;
  logic [4:0]               shamt;
  logic                     lt_s;
  logic                     lt_u;

  assign add_res = alu_a + alu_b;
  assign sub_res = alu_a - alu_b; // also the beq/bne compare
  assign shamt   = alu_b[4:0];    // rv32 ignores upper shift bits

  // signed and unsigned less-than, reused by blt/bltu/bge/bgeu
  assign lt_s = $signed(alu_a) < $signed(alu_b);
  assign lt_u = alu_a < alu_b;

  assign sra_res = $unsigned($signed(alu_a) >>> shamt);

  always_comb begin
    case (funct)
      3'b000: begin
        val = funcs ? sub_res : add_res;
      end
      3'b001: begin
        val = alu_a << shamt; // sll
      end
      3'b010: begin
        val = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
      end
      3'b011: begin
        val = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
      end
      3'b100: begin
        val = alu_a ^ alu_b;
      end
      3'b101: begin
        // logical or arithmetic right shift
        val = funcs ? sra_res : (alu_a >> shamt);
      end
      3'b110: begin
        val = alu_a | alu_b;
      end
      3'b111: begin
        val = alu_a & alu_b;
      end
      default: begin
        val = add_res;
      end
    endcase
  end

endmodule

/* hdl/exu_sys_decode.sv */
`timescale 1ns/10ps

module exu_sys_decode (
  input  exu_pkg::exu_instr_t      instr,
  input  logic [exu_pkg::xlen-1:0] alu_val,
  output exu_pkg::sys_ctl_t        ctl
);

  always_comb begin : decode
    logic is_sys;
    logic csr_op;
    logic sys_ret;
    logic ecall;

    is_sys  = instr.opcode == exu_pkg::op_sys;
    csr_op  = is_sys & (|instr.funct);          // csrrw/csrrs/... family
    sys_ret = is_sys & (instr.funct == 3'b000); // ecall or mret
    ecall   = sys_ret & (instr.imm[11:0] == 12'h000);

    // register file write per class
    case (instr.opcode)
      exu_pkg::op_lui,
      exu_pkg::op_auipc,
      exu_pkg::op_jal,
      exu_pkg::op_jalr,
      exu_pkg::op_load,
      exu_pkg::op_calri,
      exu_pkg::op_calrr: begin
        ctl.gpr_wen = 1'b1;
      end
      exu_pkg::op_sys: begin
        ctl.gpr_wen = csr_op; // only csr ops return the old value
      end
      default: begin
        ctl.gpr_wen = 1'b0; // branch, store
      end
    endcase

    ctl.is_load  = instr.opcode == exu_pkg::op_load;
    ctl.is_store = instr.opcode == exu_pkg::op_store;

    ctl.csr_jump = sys_ret;
    ctl.pc_ovrd  = (instr.opcode == exu_pkg::op_jalr) | sys_ret;

    // port 1 takes the csr op target or mepc on ecall
    // decode places pc on the alu path for ecall
    ctl.csr_wr1.wen   = csr_op | ecall;
    ctl.csr_wr1.waddr = csr_op ? instr.imm[11:0] : exu_pkg::csr_mepc;
    ctl.csr_wr1.wdata = alu_val;

    // port 2 only carries the trap cause
    ctl.csr_wr2.wen   = ecall;
    ctl.csr_wr2.waddr = exu_pkg::csr_mcause;
    ctl.csr_wr2.wdata = exu_pkg::cause_ecall;
  end

endmodule

/* hdl/exu_retire.sv */
`timescale 1ns/10ps

module exu_retire (
  input  logic                     clk,
  input  logic                     rstn,
  input  exu_pkg::exu_instr_t      instr,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [exu_pkg::xlen-1:0] alu_val,
  input  exu_pkg::sys_ctl_t        ctl,
  output logic [exu_pkg::xlen-1:0] npc,
  output logic                     gpr_wen,
  output logic [4:0]               gpr_waddr,
  output logic [exu_pkg::xlen-1:0] gpr_wdata,
  output exu_pkg::csr_wr_t         csr_wr1,
  output exu_pkg::csr_wr_t         csr_wr2,
  output exu_pkg::mem_req_t        rreq,
  output logic                     rreq_valid,
  input  logic                     rreq_ready,
  input  logic [exu_pkg::xlen-1:0] rdata,
  input  logic                     rres_valid,
  output logic                     rres_ready,
  output exu_pkg::mem_req_t        wreq,
  output logic                     wreq_valid,
  input  logic                     wreq_ready,
  input  logic                     wres_valid,
  output logic                     wres_ready
);

  localparam logic [exu_pkg::xlen-1:0] pc_step = 4;

  typedef enum logic [1:0] {
    st_idle,
    st_load_wait,
    st_store_wait
  } state_e;

  state_e state;

  logic                     accept;
  logic                     rres_hs;
  logic                     wres_hs;
  logic                     br_taken;
  logic [exu_pkg::xlen-1:0] npc_base;
  logic [exu_pkg::xlen-1:0] pc_inc;
  logic [exu_pkg::xlen-1:0] npc_sum;
  logic                     csr1_wen;
  logic                     csr2_wen;
  logic [11:0]              csr1_waddr;
  logic [11:0]              csr2_waddr;
  logic [exu_pkg::xlen-1:0] csr1_wdata;
  logic [exu_pkg::xlen-1:0] csr2_wdata;

  assign accept  = in_valid & in_ready;
  assign rres_hs = rres_valid & rres_ready;
  assign wres_hs = wres_valid & wres_ready;

  // alu holds either a difference or an slt bit here
  always_comb begin
    case (exu_pkg::branch_e'(instr.funct))
      exu_pkg::br_beq:                   br_taken = ~|alu_val;
      exu_pkg::br_bne:                   br_taken = |alu_val;
      exu_pkg::br_blt, exu_pkg::br_bltu: br_taken = alu_val[0];
      exu_pkg::br_bge, exu_pkg::br_bgeu: br_taken = ~alu_val[0];
      default:                           br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (instr.opcode)
      exu_pkg::op_jal, exu_pkg::op_jalr: pc_inc = instr.imm;
      exu_pkg::op_branch:                pc_inc = br_taken ? instr.imm : pc_step;
      exu_pkg::op_sys:                   pc_inc = ctl.csr_jump ? '0 : pc_step;
      default:                           pc_inc = pc_step;
    endcase
  end

  assign npc_base = ctl.csr_jump ? instr.csr : (ctl.pc_ovrd ? instr.src1 : instr.pc);
  assign npc_sum  = npc_base + pc_inc;
  assign npc      = {npc_sum[exu_pkg::xlen-1:1], 1'b0};

  // control state and write strobes
  always_ff @(posedge clk) begin
    if (rstn) begin
      state      <= st_idle;
      in_ready   <= 1'b1;
      gpr_wen    <= 1'b0;
      csr1_wen   <= 1'b0;
      csr2_wen   <= 1'b0;
      rreq_valid <= 1'b0;
      rres_ready <= 1'b0;
      wreq_valid <= 1'b0;
      wres_ready <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0; // strobes last one cycle
      csr1_wen <= 1'b0;
      csr2_wen <= 1'b0;
      case (state)
        st_idle: begin
          if (accept && ctl.is_load) begin
            state      <= st_load_wait;
            in_ready   <= 1'b0;
            rreq_valid <= 1'b1;
            rres_ready <= 1'b1; // ready for the response as soon as we ask
          end else if (accept && ctl.is_store) begin
            state      <= st_store_wait;
            in_ready   <= 1'b0;
            wreq_valid <= 1'b1;
            wres_ready <= 1'b1;
          end else if (accept) begin
            gpr_wen  <= ctl.gpr_wen;
            csr1_wen <= ctl.csr_wr1.wen;
            csr2_wen <= ctl.csr_wr2.wen;
          end
        end
        st_load_wait: begin
          if (rreq_valid && rreq_ready) rreq_valid <= 1'b0;
          if (rres_hs) begin
            rres_ready <= 1'b0;
            gpr_wen    <= 1'b1;
            in_ready   <= 1'b1;
            state      <= st_idle;
          end
        end
        st_store_wait: begin
          if (wreq_valid && wreq_ready) wreq_valid <= 1'b0;
          if (wres_hs) begin
            wres_ready <= 1'b0;
            in_ready   <= 1'b1;
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload captured on accept or load response
  always_ff @(posedge clk) begin
    if (accept) begin
      gpr_waddr  <= instr.rd;
      gpr_wdata  <= (instr.opcode == exu_pkg::op_sys) ? instr.csr : alu_val;
      csr1_waddr <= ctl.csr_wr1.waddr;
      csr1_wdata <= ctl.csr_wr1.wdata;
      csr2_waddr <= ctl.csr_wr2.waddr;
      csr2_wdata <= ctl.csr_wr2.wdata;
      rreq       <= '{func: instr.funct, addr: alu_val, wdata: '0};
      wreq       <= '{func: instr.funct, addr: alu_val, wdata: instr.src2};
    end
    if (rres_hs) gpr_wdata <= rdata;
  end

  assign csr_wr1 = '{wen: csr1_wen, waddr: csr1_waddr, wdata: csr1_wdata};
  assign csr_wr2 = '{wen: csr2_wen, waddr: csr2_waddr, wdata: csr2_wdata};

  // a stalled instruction stays on the port until it is taken
  a_instr_hold: assert property (@(posedge clk) disable iff (rstn)
    in_valid && !in_ready |=> in_valid && $stable(instr));

  // read request held stable until the memory unit takes it
  a_rreq_hold: assert property (@(posedge clk) disable iff (rstn)
    rreq_valid && !rreq_ready |=> rreq_valid && $stable(rreq));

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/10ps

module exu_top (
  input  logic                     clk,
  input  logic                     rstn,
  input  exu_pkg::exu_instr_t      instr,
  input  logic                     in_valid,
  output logic                     in_ready,
  output logic [exu_pkg::xlen-1:0] npc,
  output logic                     gpr_wen,
  output logic [4:0]               gpr_waddr,
  output logic [exu_pkg::xlen-1:0] gpr_wdata,
  output exu_pkg::csr_wr_t         csr_wr1,
  output exu_pkg::csr_wr_t         csr_wr2,
  output exu_pkg::mem_req_t        rreq,
  output logic                     rreq_valid,
  input  logic                     rreq_ready,
  input  logic [exu_pkg::xlen-1:0] rdata,
  input  logic                     rres_valid,
  output logic                     rres_ready,
  output exu_pkg::mem_req_t        wreq,
  output logic                     wreq_valid,
  input  logic                     wreq_ready,
  input  logic                     wres_valid,
  output logic                     wres_ready
);

  logic [exu_pkg::xlen-1:0] alu_val; // shared by decode and retire
  exu_pkg::sys_ctl_t        ctl;

  exu_alu u_alu (
    .alu_a (instr.alu_a),
    .alu_b (instr.alu_b),
    .funct (instr.alu_funct),
    .funcs (instr.alu_funcs),
    .val   (alu_val)
  );

  // runs next to the alu on the same instruction
  exu_sys_decode u_sys_decode (
    .instr   (instr),
    .alu_val (alu_val),
    .ctl     (ctl)
  );

  exu_retire u_retire (
    .clk        (clk),
    .rstn       (rstn),
    .instr      (instr),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .alu_val    (alu_val),
    .ctl        (ctl),
    .npc        (npc),
    .gpr_wen    (gpr_wen),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata),
    .csr_wr1    (csr_wr1),
    .csr_wr2    (csr_wr2),
    .rreq       (rreq),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .wreq       (wreq),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready)
  );

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // reset high over the first three rising edges
  initial begin
    rstn = 1'b1;
    repeat (3) @(posedge clk);
    #1 rstn = 1'b0;
  end

endmodule

/* sim/tb_exu_model.svh */
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

// expected results built from the instruction fields alone

function automatic logic [31:0] ref_alu(input logic [31:0] a, input logic [31:0] b,
                                        input logic [2:0] op, input logic alt);
  logic [4:0]  sh;
  logic [31:0] fill;
  sh   = b[4:0];
  fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0; // sign bits shifted in by sra
  case (op)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << sh;
    3'd2:    return {31'h0, $signed(a) < $signed(b)};
    3'd3:    return {31'h0, a < b};
    3'd4:    return a ^ b;
    3'd5:    return alt ? ((a >> sh) | fill) : (a >> sh);
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic ref_taken(input logic [2:0] f, input logic [31:0] a,
                                   input logic [31:0] b);
  case (f)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic logic is_ecall(input exu_pkg::exu_instr_t ins);
  return ins.opcode == exu_pkg::op_sys && ins.funct == 3'b000 && ins.imm[11:0] == 12'h000;
endfunction

function automatic logic [31:0] ref_npc(input exu_pkg::exu_instr_t ins);
  logic [31:0] base;
  logic [31:0] step;
  base = ins.pc;
  step = 32'd4;
  case (ins.opcode)
    exu_pkg::op_jal: step = ins.imm;
    exu_pkg::op_jalr: begin
      base = ins.src1;
      step = ins.imm;
    end
    exu_pkg::op_branch: begin
      if (ref_taken(ins.funct, ins.src1, ins.src2)) step = ins.imm;
    end
    exu_pkg::op_sys: begin
      if (ins.funct == 3'b000) begin // ecall / mret jump to csr value
        base = ins.csr;
        step = 32'd0;
      end
    end
    default: step = 32'd4;
  endcase
  return (base + step) & ~32'h1;
endfunction

function automatic logic ref_gpr_wen(input exu_pkg::exu_instr_t ins);
  case (ins.opcode)
    exu_pkg::op_branch, exu_pkg::op_store: return 1'b0;
    exu_pkg::op_sys:                       return ins.funct != 3'b000;
    default:                               return 1'b1;
  endcase
endfunction

function automatic logic [31:0] ref_gpr_data(input exu_pkg::exu_instr_t ins);
  case (ins.opcode)
    exu_pkg::op_lui:                   return ins.imm;
    exu_pkg::op_auipc:                 return ins.pc + ins.imm;
    exu_pkg::op_jal, exu_pkg::op_jalr: return ins.pc + 32'd4; // link address
    exu_pkg::op_calri: return ref_alu(ins.src1, ins.imm, ins.funct, ins.alu_funcs);
    exu_pkg::op_calrr: return ref_alu(ins.src1, ins.src2, ins.funct, ins.alu_funcs);
    exu_pkg::op_sys:                   return ins.csr; // old csr value to rd
    default:                           return 32'h0;
  endcase
endfunction

function automatic exu_pkg::csr_wr_t ref_csr1(input exu_pkg::exu_instr_t ins);
  exu_pkg::csr_wr_t w;
  w = '0;
  if (ins.opcode == exu_pkg::op_sys && ins.funct != 3'b000) begin
    w.wen   = 1'b1;
    w.waddr = ins.imm[11:0];
    case (ins.funct[1:0])
      2'b01:   w.wdata = ins.src1;             // csrrw
      2'b10:   w.wdata = ins.csr | ins.src1;   // csrrs
      default: w.wdata = ins.csr & ~ins.src1;  // csrrc
    endcase
  end else if (is_ecall(ins)) begin
    w.wen   = 1'b1;
    w.waddr = exu_pkg::csr_mepc;
    w.wdata = ins.pc;
  end
  return w;
endfunction

function automatic exu_pkg::csr_wr_t ref_csr2(input exu_pkg::exu_instr_t ins);
  exu_pkg::csr_wr_t w;
  w = '0;
  if (is_ecall(ins)) begin
    w.wen   = 1'b1;
    w.waddr = exu_pkg::csr_mcause;
    w.wdata = 32'd11;
  end
  return w;
endfunction

`endif

/* sim/tb_exu.sv */
`timescale 1ns/10ps

module tb_exu;

  localparam int n_instr    = 400;
  localparam int max_cycles = n_instr * 12;

  logic                clk;
  logic                rstn;
  exu_pkg::exu_instr_t instr;
  logic                in_valid;
  logic                in_ready;
  logic [31:0]         npc;
  logic                gpr_wen;
  logic [4:0]          gpr_waddr;
  logic [31:0]         gpr_wdata;
  exu_pkg::csr_wr_t    csr_wr1;
  exu_pkg::csr_wr_t    csr_wr2;
  exu_pkg::mem_req_t   rreq;
  logic                rreq_valid;
  logic                rreq_ready;
  logic [31:0]         rdata;
  logic                rres_valid;
  logic                rres_ready;
  exu_pkg::mem_req_t   wreq;
  logic                wreq_valid;
  logic                wreq_ready;
  logic                wres_valid;
  logic                wres_ready;

  logic [31:0]         lfsr;
  logic [31:0]         mem [16];  // memory responder storage
  exu_pkg::exu_instr_t cur;       // instruction on the input port
  int                  issued = 0;
  int                  accepted = 0;
  int                  cycles = 0;
  int                  rd_delay = 0;
  int                  wr_delay = 0;
  logic                ld_busy = 0;
  logic                st_busy = 0;
  logic                rq_out = 0;
  logic                rd_pend = 0;
  logic                wr_pend = 0;
  logic                acc;
  logic                rq_hs;
  logic                wq_hs;
  logic                rs_hs;
  logic                ws_hs;
  logic                exp_gpr = 0;
  logic [4:0]          exp_waddr;
  logic [31:0]         exp_wdata;
  logic [4:0]          ld_rd;
  exu_pkg::csr_wr_t    exp_c1 = '0;
  exu_pkg::csr_wr_t    exp_c2 = '0;
  exu_pkg::mem_req_t   exp_req;

  `include "tb_exu_model.svh"

  clk_gen u_clk_gen (.clk(clk), .rstn(rstn));

  exu_top i_exu_top (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  // one lfsr step per bit returned
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] sign_ext(input logic [31:0] v, input int w);
    logic [31:0] up;
    up = v << (32 - w);
    return $unsigned($signed(up) >>> (32 - w));
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic make_instr(output exu_pkg::exu_instr_t ins);
    logic [3:0] kind;
    int         pick;
    ins       = '0;
    ins.pc    = rand_bits(32) & ~32'h3;
    ins.rd    = 5'(rand_bits(5));
    ins.src1  = rand_bits(32);
    ins.src2  = rand_bits(32);
    ins.csr   = rand_bits(32);
    ins.imm   = sign_ext(rand_bits(12), 12);
    ins.alu_a = ins.src1; // address add for loads and stores
    ins.alu_b = ins.imm;
    kind      = 4'(rand_bits(4));
    case (kind)
      4'd0, 4'd1: begin
        ins.opcode = (kind == 4'd0) ? exu_pkg::op_lui : exu_pkg::op_auipc;
        ins.imm    = rand_bits(32) & 32'hffff_f000;
        ins.alu_a  = (kind == 4'd0) ? 32'h0 : ins.pc;
        ins.alu_b  = ins.imm;
      end
      4'd2, 4'd3: begin
        ins.opcode = (kind == 4'd2) ? exu_pkg::op_jal : exu_pkg::op_jalr;
        if (kind == 4'd2) ins.imm = sign_ext(rand_bits(20), 20) << 1;
        ins.alu_a = ins.pc; // link = pc + 4
        ins.alu_b = 32'd4;
      end
      4'd4, 4'd5: begin
        ins.opcode = exu_pkg::op_branch;
        pick       = int'(rand_bits(3)) % 6;
        ins.funct  = (pick < 2) ? 3'(pick) : 3'(pick + 2);
        if (rand_bits(2) == 0) ins.src2 = ins.src1; // equal operands now and then
        ins.imm   = sign_ext(rand_bits(12), 12) << 1;
        ins.alu_a = ins.src1;
        ins.alu_b = ins.src2;
        case (ins.funct[2:1])
          2'b00:   ins.alu_funcs = 1'b1;    // sub for beq/bne
          2'b10:   ins.alu_funct = 3'b010;
          default: ins.alu_funct = 3'b011;
        endcase
      end
      4'd6, 4'd7: begin
        ins.opcode = exu_pkg::op_load;
        pick       = int'(rand_bits(3)) % 5;
        ins.funct  = (pick < 3) ? 3'(pick) : 3'(pick + 1);
      end
      4'd8, 4'd9: begin
        ins.opcode = exu_pkg::op_store;
        ins.funct  = 3'(int'(rand_bits(2)) % 3);
      end
      4'd10, 4'd11, 4'd12, 4'd15: begin
        ins.opcode    = (kind < 4'd11 || kind == 4'd15) ? exu_pkg::op_calri : exu_pkg::op_calrr;
        ins.funct     = 3'(rand_bits(3));
        ins.alu_funct = ins.funct;
        if (ins.opcode == exu_pkg::op_calrr) ins.alu_b = ins.src2;
        if (ins.funct == 3'd5 || (ins.funct == 3'd0 && ins.opcode == exu_pkg::op_calrr))
          ins.alu_funcs = 1'(rand_bits(1));
      end
      default: begin
        ins.opcode = exu_pkg::op_sys;
        if (rand_bits(2) == 0) begin
          ins.imm   = (rand_bits(1) != 0) ? 32'h302 : 32'h0; // mret or ecall
          ins.alu_a = ins.pc;
          ins.alu_b = 32'h0;
        end else begin
          pick      = int'(rand_bits(3)) % 6;
          ins.funct = (pick < 3) ? 3'(pick + 1) : 3'(pick + 2);
          ins.imm   = rand_bits(12); // csr address
          case (ins.funct[1:0])
            2'b01: ins.alu_b = 32'h0;
            2'b10: begin
              ins.alu_a     = ins.csr;
              ins.alu_b     = ins.src1;
              ins.alu_funct = 3'b110;
            end
            default: begin
              ins.alu_a     = ins.csr;
              ins.alu_b     = ~ins.src1;
              ins.alu_funct = 3'b111;
            end
          endcase
        end
      end
    endcase
  endtask

  // drives the memory side just after each rising edge
  task automatic drive_memory();
    rreq_ready = rand_bits(2) != 0;
    wreq_ready = rand_bits(2) != 0;
    if (rs_hs) {rres_valid, rd_pend} = 2'b00;
    if (ws_hs) {wres_valid, wr_pend} = 2'b00;
    if (rq_hs) begin
      rd_pend  = 1'b1;
      rd_delay = int'(rand_bits(3)) % 6;
    end
    if (wq_hs) begin
      mem[exp_req.addr[5:2]] = exp_req.wdata;
      wr_pend  = 1'b1;
      wr_delay = int'(rand_bits(3)) % 6;
    end
    if (rd_pend && !rres_valid) begin
      if (rd_delay == 0) begin
        rres_valid = 1'b1;
        rdata      = mem[exp_req.addr[5:2]];
      end else rd_delay--;
    end
    if (wr_pend && !wres_valid) begin
      if (wr_delay == 0) wres_valid = 1'b1;
      else wr_delay--;
    end
  endtask

  initial begin
    lfsr       = 32'h403c;
    instr      = '0;
    in_valid   = 1'b0;
    rreq_ready = 1'b0;
    rdata      = '0;
    rres_valid = 1'b0;
    wreq_ready = 1'b0;
    wres_valid = 1'b0;
    for (int i = 0; i < 16; i++) mem[i] = 32'h9e37_79b9 * 32'(i + 1);
    wait (rstn === 1'b1);
    wait (rstn === 1'b0);
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        $display("timeout: the DUT did not finish within %0d cycles", max_cycles);
        $display("sim failed");
        $fatal(1, "timeout");
      end
      check_eq(32'(gpr_wen), 32'(exp_gpr), "gpr_wen");
      if (exp_gpr) begin
        check_eq(32'(gpr_waddr), 32'(exp_waddr), "gpr_waddr");
        check_eq(gpr_wdata, exp_wdata, "gpr_wdata");
      end
      check_eq(32'(csr_wr1.wen), 32'(exp_c1.wen), "csr_wr1.wen");
      if (exp_c1.wen) begin
        check_eq(32'(csr_wr1.waddr), 32'(exp_c1.waddr), "csr_wr1.waddr");
        check_eq(csr_wr1.wdata, exp_c1.wdata, "csr_wr1.wdata");
      end
      check_eq(32'(csr_wr2.wen), 32'(exp_c2.wen), "csr_wr2.wen");
      if (exp_c2.wen) begin
        check_eq(32'(csr_wr2.waddr), 32'(exp_c2.waddr), "csr_wr2.waddr");
        check_eq(csr_wr2.wdata, exp_c2.wdata, "csr_wr2.wdata");
      end
      check_eq(32'(in_ready), 32'(!(ld_busy || st_busy)), "in_ready");
      check_eq(32'(rreq_valid), 32'(ld_busy && rq_out), "rreq_valid");
      check_eq(32'(rres_ready), 32'(ld_busy), "rres_ready");
      check_eq(32'(wreq_valid), 32'(st_busy && rq_out), "wreq_valid");
      check_eq(32'(wres_ready), 32'(st_busy), "wres_ready");
      if (rreq_valid) begin
        check_eq(rreq.addr, exp_req.addr, "rreq.addr");
        check_eq(32'(rreq.func), 32'(exp_req.func), "rreq.func");
      end
      if (wreq_valid) begin
        check_eq(wreq.addr, exp_req.addr, "wreq.addr");
        check_eq(wreq.wdata, exp_req.wdata, "wreq.wdata");
        check_eq(32'(wreq.func), 32'(exp_req.func), "wreq.func");
      end
      if (in_valid) check_eq(npc, ref_npc(cur), "npc");
      // handshakes that complete at the coming edge
      acc   = in_valid && in_ready;
      rq_hs = rreq_valid && rreq_ready;
      wq_hs = wreq_valid && wreq_ready;
      rs_hs = rres_valid && rres_ready;
      ws_hs = wres_valid && wres_ready;
      exp_gpr = 1'b0;
      exp_c1  = '0;
      exp_c2  = '0;
      if (acc) begin
        accepted++;
        exp_req = '{func: cur.funct, addr: cur.src1 + cur.imm, wdata: cur.src2};
        if (cur.opcode == exu_pkg::op_load) begin
          {ld_busy, rq_out} = 2'b11;
          ld_rd = cur.rd;
        end else if (cur.opcode == exu_pkg::op_store) begin
          {st_busy, rq_out} = 2'b11;
        end else begin
          exp_gpr   = ref_gpr_wen(cur);
          exp_waddr = cur.rd;
          exp_wdata = ref_gpr_data(cur);
          exp_c1    = ref_csr1(cur);
          exp_c2    = ref_csr2(cur);
        end
      end
      if (rq_hs || wq_hs) rq_out = 1'b0;
      if (rs_hs) begin // load data written back next cycle
        exp_gpr   = 1'b1;
        exp_waddr = ld_rd;
        exp_wdata = rdata;
        ld_busy   = 1'b0;
      end
      if (ws_hs) st_busy = 1'b0;
      @(posedge clk);
      #1;
      drive_memory();
      if (acc || !in_valid) begin
        if (issued < n_instr && rand_bits(2) != 0) begin
          make_instr(cur);
          instr    = cur;
          in_valid = 1'b1;
          issued++;
        end else in_valid = 1'b0; // idle cycle
      end
    end while (issued < n_instr || in_valid || ld_busy || st_busy || exp_gpr ||
               exp_c1.wen || exp_c2.wen);
    check_eq(32'(accepted), 32'(n_instr), "accepted instruction count");
    $display("sim passed");
    $finish;
  end

endmodule

/* rv_exu.f */
+incdir+sim
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_sys_decode.sv
hdl/exu_retire.sv
hdl/exu_top.sv
sim/clk_gen.sv
sim/tb_exu.sv

/* build_sim.sh */
#!/bin/sh
# compile and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_exu -Mdir obj_dir -o sim_exu -f rv_exu.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_exu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: pass message not found in $LOG"
exit 1
